/* gfx_pkg.sv */
// drawing types shared by renderer, address stage and scanout
// import with gfx_pkg::* in the module header
package gfx_pkg;

    localparam int CORDW = 16;  // signed coordinate width
    localparam int CIDXW = 4;   // colour index width

    typedef logic signed [CORDW-1:0] coord_t;
    typedef logic [CIDXW-1:0] cidx_t;
    typedef logic [11:0] colr_t;  // 4 bits each, red on top

    // draw command opcodes
    typedef enum logic [1:0] {
        OP_CLEAR = 2'd0,  // whole buffer, coords ignored
        OP_RECT  = 2'd1,  // filled, corners inclusive
        OP_NOP   = 2'd2   // ack only
    } draw_op_e;

    // fixed 16 colour palette, index 0 is dark but not black
    localparam colr_t PALETTE [16] = '{
        12'h112, 12'h525, 12'hb35, 12'he75,
        12'hfc7, 12'hae7, 12'h3b6, 12'h277,
        12'h236, 12'h35c, 12'h4af, 12'h7ef,
        12'hfff, 12'h9bc, 12'h568, 12'h335
    };

endpackage

/* video_pkg.sv */
// display timing and scanout definitions
// tiny raster so a frame simulates in about a thousand cycles
package video_pkg;

    // horizontal, in pixels
    localparam int H_ACTIVE = 32;
    localparam int H_TOTAL  = 40;  // 8 blanking

    // vertical, in lines
    localparam int V_ACTIVE = 24;
    localparam int V_TOTAL  = 28;  // 4 blanking

    // linebuffer fetch FSM
    typedef enum logic {
        LB_IDLE,  // waiting for a line pulse
        LB_FILL   // copying one buffer row
    } lb_state_e;

endpackage

/* pix_if.sv */
// pixel stream from renderer to address stage
// one pixel per cycle while valid, no back-pressure
`timescale 1ns/1ps

interface pix_if import gfx_pkg::*; ();

    logic   valid;  // pixel present this cycle
    coord_t x;      // may be off the bitmap
    coord_t y;
    cidx_t  cidx;   // colour index

    modport src (output valid, output x, output y, output cidx);
    modport dst (input valid, input x, input y, input cidx);

endinterface

/* display_timing.sv */
// screen position counters for the small raster in video_pkg
// de, line and frame are decoded from the registered position
`timescale 1ns/1ps

module display_timing import gfx_pkg::*, video_pkg::*; (
    input  logic   clk_sys,
    input  logic   rst_sys,
    output coord_t sx,     // horizontal position
    output coord_t sy,     // vertical position
    output logic   de,     // active area
    output logic   line,   // start of each line
    output logic   frame   // start of frame
);

    logic h_last;  // last pixel of a line
    logic v_last;  // last line of a frame

    always_comb begin
        h_last = (sx == coord_t'(H_TOTAL - 1));
        v_last = (sy == coord_t'(V_TOTAL - 1));
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            sx <= '0;
            sy <= '0;
        end else if (h_last) begin
            sx <= '0;
            sy <= v_last ? '0 : sy + coord_t'(1);  // next line or wrap
        end else begin
            sx <= sx + coord_t'(1);
        end
    end

    // decode, no extra register stage
    always_comb begin
        de    = (sx < coord_t'(H_ACTIVE)) && (sy < coord_t'(V_ACTIVE));
        line  = (sx == '0);
        frame = (sx == '0) && (sy == '0);
    end

endmodule

/* render_rect.sv */
// draw command engine, takes one command per four-phase req/ack
// walks rectangles and clears row-major onto the pixel stream
`timescale 1ns/1ps

module render_rect import gfx_pkg::*; #(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 12
) (
    input  logic     clk_sys,
    input  logic     rst_sys,
    input  logic     cmd_req,
    input  draw_op_e cmd_op,
    input  coord_t   cmd_x0,
    input  coord_t   cmd_y0,
    input  coord_t   cmd_x1,
    input  coord_t   cmd_y1,
    input  cidx_t    cmd_cidx,
    output logic     cmd_ack,
    pix_if.src       pix
);

    typedef enum logic [1:0] {
        IDLE,  // wait for cmd_req
        DRAW,  // one pixel per cycle
        ACK    // hold ack until req drops
    } state_e;

    state_e state;

    coord_t rx0;  // row start, reloaded at each row wrap
    coord_t rx1;  // row end
    coord_t ry1;  // last row

    // command as a rectangle, clear becomes the full buffer
    coord_t c_x0, c_y0, c_x1, c_y1;
    logic   c_empty;

    always_comb begin
        if (cmd_op == OP_CLEAR) begin
            c_x0 = '0;
            c_y0 = '0;
            c_x1 = coord_t'(FB_WIDTH - 1);
            c_y1 = coord_t'(FB_HEIGHT - 1);
        end else begin
            c_x0 = cmd_x0;
            c_y0 = cmd_y0;
            c_x1 = cmd_x1;
            c_y1 = cmd_y1;
        end
        c_empty = (cmd_op == OP_NOP) || (c_x1 < c_x0) || (c_y1 < c_y0);  // signed compare
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state     <= IDLE;
            cmd_ack   <= 1'b0;
            pix.valid <= 1'b0;
        end else begin
            case (state)
                IDLE: if (cmd_req) begin
                    rx0      <= c_x0;
                    rx1      <= c_x1;
                    ry1      <= c_y1;
                    pix.x    <= c_x0;  // first pixel out next cycle
                    pix.y    <= c_y0;
                    pix.cidx <= cmd_cidx;
                    if (c_empty) begin
                        state   <= ACK;  // nothing to draw
                        cmd_ack <= 1'b1;
                    end else begin
                        state     <= DRAW;
                        pix.valid <= 1'b1;
                    end
                end
                DRAW: begin
                    if (pix.x == rx1) begin
                        if (pix.y == ry1) begin  // last pixel on the bus now
                            pix.valid <= 1'b0;
                            cmd_ack   <= 1'b1;
                            state     <= ACK;
                        end else begin
                            pix.x <= rx0;  // next row
                            pix.y <= pix.y + coord_t'(1);
                        end
                    end else begin
                        pix.x <= pix.x + coord_t'(1);
                    end
                end
                ACK: if (!cmd_req) begin
                    cmd_ack <= 1'b0;  // handshake closes here
                    state   <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* bitmap_addr.sv */
// maps stream coordinates to framebuffer addresses, two cycles
// off-bitmap pixels keep their slot in the pipe but never write
`timescale 1ns/1ps

module bitmap_addr import gfx_pkg::*; #(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 12,
    parameter int FB_ADDRW  = 8
) (
    input  logic                clk_sys,
    input  logic                rst_sys,
    pix_if.dst                  pix,
    output logic                we,
    output logic [FB_ADDRW-1:0] addr_write,
    output cidx_t               data_in
);

    // stage one
    logic                vld1;
    logic                clip1;     // outside the bitmap
    logic [FB_ADDRW-1:0] row_base;  // y * FB_WIDTH
    logic [FB_ADDRW-1:0] col1;
    cidx_t               cidx1;

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            vld1 <= 1'b0;
            we   <= 1'b0;
        end else begin
            vld1 <= pix.valid;
            we   <= vld1 && !clip1;  // stage two enable
        end
    end

    always_ff @(posedge clk_sys) begin
        clip1    <= (pix.x < 0) || (pix.x >= coord_t'(FB_WIDTH))
                 || (pix.y < 0) || (pix.y >= coord_t'(FB_HEIGHT));
        row_base <= FB_ADDRW'(pix.y * FB_WIDTH);  // junk when clipped
        col1     <= FB_ADDRW'(pix.x);
        cidx1    <= pix.cidx;
        // stage two, colour rides with its address
        addr_write <= row_base + col1;
        data_in    <= cidx1;
    end

endmodule

/* bram_sdp.sv */
// simple dual-port memory, one write port and one read port
// read data appears the cycle after the address
`timescale 1ns/1ps

module bram_sdp #(
    parameter int WIDTH = 4,
    parameter int DEPTH = 192,
    parameter int ADDRW = 8
) (
    input  logic             clk_sys,
    input  logic             we,
    input  logic [ADDRW-1:0] addr_write,
    input  logic [WIDTH-1:0] data_in,
    input  logic [ADDRW-1:0] addr_read,
    output logic [WIDTH-1:0] data_out
);

    logic [WIDTH-1:0] mem [DEPTH];  // contents undefined until written

    always_ff @(posedge clk_sys) begin
        if (we) mem[addr_write] <= data_in;
        data_out <= mem[addr_read];  // registered read
    end

endmodule

/* scanout.sv */
// framebuffer to video, fetches the next buffer row into a spare bank
// scales by FB_SCALE, looks up PALETTE and registers all video outputs
`timescale 1ns/1ps

module scanout import gfx_pkg::*, video_pkg::*; #(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 12,
    parameter int FB_SCALE  = 2,
    parameter int FB_ADDRW  = 8
) (
    input  logic                clk_sys,
    input  logic                rst_sys,
    input  coord_t              sx,
    input  coord_t              sy,
    input  logic                de,
    input  logic                line,
    input  logic                frame,
    input  cidx_t               data_out,   // from framebuffer
    output logic [FB_ADDRW-1:0] addr_read,
    output coord_t              vid_sx,
    output coord_t              vid_sy,
    output logic                vid_de,
    output logic                vid_frame,
    output logic [7:0]          vid_r,
    output logic [7:0]          vid_g,
    output logic [7:0]          vid_b
);

    localparam int LBW    = (FB_WIDTH > 1) ? $clog2(FB_WIDTH) : 1;
    localparam int AREA_W = FB_WIDTH * FB_SCALE;   // scaled size on screen
    localparam int AREA_H = FB_HEIGHT * FB_SCALE;

    cidx_t     lb [2][FB_WIDTH];  // two banks, one shown, one filling
    logic      bank_sel;          // bank on display
    logic      swap_pend;         // filled bank waits for next line
    lb_state_e lb_state;
    logic [LBW-1:0] rd_idx;       // entry of the address on addr_read
    logic [LBW-1:0] wr_idx;       // entry of data_out
    logic      rd_vld;

    // does the next screen line start a new buffer row
    coord_t              nl;
    logic                fetch;
    logic [FB_ADDRW-1:0] row_addr;

    always_comb begin
        nl       = (sy == coord_t'(V_TOTAL - 1)) ? '0 : sy + coord_t'(1);  // last line -> row 0
        fetch    = (nl < coord_t'(AREA_H)) && (nl % FB_SCALE == 0);
        row_addr = FB_ADDRW'((nl / FB_SCALE) * FB_WIDTH);
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            lb_state  <= LB_IDLE;
            bank_sel  <= 1'b0;
            swap_pend <= 1'b0;
            rd_vld    <= 1'b0;
        end else begin
            rd_vld <= (lb_state == LB_FILL);  // bram read latency
            if (line) begin
                if (swap_pend) bank_sel <= ~bank_sel;
                swap_pend <= fetch;
            end
            case (lb_state)
                LB_IDLE: if (line && fetch) lb_state <= LB_FILL;
                LB_FILL: if (rd_idx == LBW'(FB_WIDTH - 1)) lb_state <= LB_IDLE;
                default: lb_state <= LB_IDLE;
            endcase
        end
    end

    // row address walk and bank fill, filling bank is never on display
    always_ff @(posedge clk_sys) begin
        if (line && fetch) begin
            addr_read <= row_addr;
            rd_idx    <= '0;
        end else if (lb_state == LB_FILL) begin
            addr_read <= addr_read + 1'b1;
            rd_idx    <= rd_idx + 1'b1;
        end
        wr_idx <= rd_idx;
        if (rd_vld) lb[~bank_sel][wr_idx] <= data_out;
    end

    // display side
    logic           in_area;
    logic [LBW-1:0] lb_x;
    logic           rd_bank;

    always_comb begin
        in_area = de && (sx < coord_t'(AREA_W)) && (sy < coord_t'(AREA_H));
        lb_x    = in_area ? LBW'(sx / FB_SCALE) : '0;  // keep index in range
        rd_bank = (line && swap_pend) ? ~bank_sel : bank_sel;  // swap lands this cycle
    end

    // stage one, linebuffer read
    cidx_t  p1_cidx;
    logic   p1_area, p1_de, p1_frame;
    coord_t p1_sx, p1_sy;

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            p1_de     <= 1'b0;
            p1_frame  <= 1'b0;
            vid_de    <= 1'b0;
            vid_frame <= 1'b0;
        end else begin
            p1_de     <= de;
            p1_frame  <= frame;
            vid_de    <= p1_de;
            vid_frame <= p1_frame;
        end
    end

    colr_t colr;  // black outside the scaled area
    always_comb colr = p1_area ? PALETTE[p1_cidx] : '0;

    always_ff @(posedge clk_sys) begin
        p1_cidx <= lb[rd_bank][lb_x];
        p1_area <= in_area;
        p1_sx   <= sx;
        p1_sy   <= sy;
        // stage two, palette and outputs together
        vid_sx <= p1_sx;
        vid_sy <= p1_sy;
        vid_r  <= {2{colr[11:8]}};  // 4 to 8 bits
        vid_g  <= {2{colr[7:4]}};
        vid_b  <= {2{colr[3:0]}};
    end

endmodule

/* fb_demo_top.sv */
// framebuffer graphics top, draw commands in, video out
// buffer size and scale are set here and passed to every block
`timescale 1ns/1ps

module fb_demo_top import gfx_pkg::*; #(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 12,
    parameter int FB_SCALE  = 2
) (
    input  logic     clk_sys,
    input  logic     rst_sys,
    input  logic     cmd_req,
    input  draw_op_e cmd_op,
    input  coord_t   cmd_x0,
    input  coord_t   cmd_y0,
    input  coord_t   cmd_x1,
    input  coord_t   cmd_y1,
    input  cidx_t    cmd_cidx,
    output logic     cmd_ack,
    output coord_t   vid_sx,
    output coord_t   vid_sy,
    output logic     vid_de,
    output logic     vid_frame,
    output logic [7:0] vid_r,
    output logic [7:0] vid_g,
    output logic [7:0] vid_b
);

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);

    coord_t sx, sy;
    logic   de, line, frame;

    display_timing display_timing_inst (
        .clk_sys, .rst_sys, .sx, .sy, .de, .line, .frame
    );

    pix_if pix ();  // renderer to address stage

    render_rect #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) render_rect_inst (
        .clk_sys, .rst_sys, .cmd_req, .cmd_op,
        .cmd_x0, .cmd_y0, .cmd_x1, .cmd_y1, .cmd_cidx,
        .cmd_ack, .pix(pix.src)
    );

    logic                we;
    logic [FB_ADDRW-1:0] addr_write, addr_read;
    cidx_t               data_in, data_out;

    bitmap_addr #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .FB_ADDRW(FB_ADDRW)
    ) bitmap_addr_inst (
        .clk_sys, .rst_sys, .pix(pix.dst), .we, .addr_write, .data_in
    );

    bram_sdp #(.WIDTH(CIDXW), .DEPTH(FB_PIXELS), .ADDRW(FB_ADDRW)) bram_sdp_inst (
        .clk_sys, .we, .addr_write, .data_in, .addr_read, .data_out
    );

    scanout #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT),
        .FB_SCALE(FB_SCALE), .FB_ADDRW(FB_ADDRW)
    ) scanout_inst (
        .clk_sys, .rst_sys, .sx, .sy, .de, .line, .frame, .data_out,
        .addr_read, .vid_sx, .vid_sy, .vid_de, .vid_frame,
        .vid_r, .vid_g, .vid_b
    );

endmodule

/* fb_demo_checker.sv */
// concurrent checks on the command handshake and the video outputs
// attached to fb_demo_top by the bind at the end of this file
`timescale 1ns/1ps

module fb_demo_checker import gfx_pkg::*, video_pkg::*; (
    input logic   clk_sys,
    input logic   rst_sys,
    input logic   cmd_req,
    input logic   cmd_ack,
    input coord_t vid_sx,
    input coord_t vid_sy,
    input logic   vid_de,
    input logic   vid_frame
);

    int fail_count = 0;  // summed into the final verdict

    ack_rise: assert property (@(posedge clk_sys) disable iff (rst_sys)
        $rose(cmd_ack) |-> cmd_req)
    else begin
        fail_count++;
        $error("cmd_ack rose while cmd_req was low");
    end

    ack_fall: assert property (@(posedge clk_sys) disable iff (rst_sys)
        $fell(cmd_ack) |-> !cmd_req && !$past(cmd_req))  // req dropped first
    else begin
        fail_count++;
        $error("cmd_ack fell before cmd_req was low");
    end

    frame_len: assert property (@(posedge clk_sys) disable iff (rst_sys)
        vid_frame |=> !vid_frame)
    else begin
        fail_count++;
        $error("vid_frame longer than one cycle");
    end

    de_area: assert property (@(posedge clk_sys) disable iff (rst_sys)
        vid_de |-> (vid_sx < coord_t'(H_ACTIVE)) && (vid_sy < coord_t'(V_ACTIVE)))
    else begin
        fail_count++;
        $error("vid_de high outside the active area");
    end

    // first cycle out of reset
    post_reset: assert property (@(posedge clk_sys)
        $fell(rst_sys) |-> !vid_de && !cmd_ack)
    else begin
        fail_count++;
        $error("vid_de or cmd_ack high right after reset");
    end

endmodule

bind fb_demo_top fb_demo_checker checker_inst (
    .clk_sys, .rst_sys, .cmd_req, .cmd_ack,
    .vid_sx, .vid_sy, .vid_de, .vid_frame
);

/* tb_fb_demo.sv */
// testbench for the framebuffer demo, sends draw commands over req/ack
// and compares each displayed frame with a shadow framebuffer
`timescale 1ns/1ps

module tb_fb_demo import gfx_pkg::*, video_pkg::*; ();

    localparam int FB_WIDTH     = 16;
    localparam int FB_HEIGHT    = 12;
    localparam int FB_SCALE     = 2;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int ACK_TIMEOUT  = 2000;  // largest random rect is ~500 cycles

    logic       clk_sys = 1'b0;
    logic       rst_sys;
    logic       cmd_req;
    draw_op_e   cmd_op;
    coord_t     cmd_x0, cmd_y0, cmd_x1, cmd_y1;
    cidx_t      cmd_cidx;
    logic       cmd_ack;
    coord_t     vid_sx, vid_sy;
    logic       vid_de, vid_frame;
    logic [7:0] vid_r, vid_g, vid_b;

    int    value_errors = 0;  // wrong pixels or counts
    int    other_errors = 0;  // timeouts
    string test_name = "reset";
    cidx_t shadow [FB_WIDTH*FB_HEIGHT];  // expected buffer contents

    // frame comparer control
    logic compare_en   = 1'b0;
    logic compare_done = 1'b0;
    int   win_left     = 0;  // cycles left in the compared frame
    int   de_count;
    int   frame_count;

    always #50 clk_sys = ~clk_sys;  // 100 ns period

    fb_demo_top #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .FB_SCALE(FB_SCALE)
    ) fb_demo_top_inst (.*);

    // shadow update, clipped to the buffer, empty rects fall out of the loops
    function automatic void draw_shadow(input draw_op_e op, input int x0, input int y0,
                                        input int x1, input int y1, input cidx_t c);
        int xa, ya, xb, yb, x, y;
        if (op == OP_NOP) return;
        if (op == OP_CLEAR) begin
            xa = 0;
            ya = 0;
            xb = FB_WIDTH - 1;
            yb = FB_HEIGHT - 1;
        end else begin
            xa = x0;
            ya = y0;
            xb = x1;
            yb = y1;
        end
        for (y = ya; y <= yb; y++)
            for (x = xa; x <= xb; x++)
                if (x >= 0 && x < FB_WIDTH && y >= 0 && y < FB_HEIGHT)
                    shadow[y*FB_WIDTH + x] = c;
    endfunction

    // expected {r,g,b} at a screen position
    function automatic logic [23:0] expected_rgb(input coord_t x, input coord_t y);
        colr_t c;
        if (x >= 0 && y >= 0 && x < FB_WIDTH*FB_SCALE && y < FB_HEIGHT*FB_SCALE
            && x < H_ACTIVE && y < V_ACTIVE)
            c = PALETTE[shadow[(int'(y) / FB_SCALE) * FB_WIDTH + int'(x) / FB_SCALE]];
        else
            c = '0;  // black outside the scaled buffer
        return {c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]};  // 4 to 8 bits
    endfunction

    // counts line, then the verdict
    task automatic finish_run();
        int assert_errors;
        assert_errors = fb_demo_top_inst.checker_inst.fail_count;
        $display("errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, assert_errors);
        if (value_errors + other_errors + assert_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        other_errors++;
        $display("timeout in %s while waiting for %s", test_name, what);
        finish_run();
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        @(negedge clk_sys);  // sample away from the active edge
        while (cmd_ack !== level) begin
            if (n == ACK_TIMEOUT) give_up(level ? "cmd_ack to rise" : "cmd_ack to fall");
            @(negedge clk_sys);
            n++;
        end
    endtask

    task automatic wait_vid_frame();
        int n;
        n = 0;
        @(negedge clk_sys);
        while (vid_frame !== 1'b1) begin
            if (n == FRAME_CYCLES + 4) give_up("vid_frame");
            @(negedge clk_sys);
            n++;
        end
    endtask

    // second frame pulse after the command is the one that is compared
    task automatic check_frame();
        int n;
        wait_vid_frame();
        @(negedge clk_sys);  // pulse is over, arm on a quiet cycle
        compare_done = 1'b0;
        compare_en   = 1'b1;
        n = 0;
        while (!compare_done) begin
            if (n == 2*FRAME_CYCLES + 8) give_up("frame compare");
            @(negedge clk_sys);
            n++;
        end
    endtask

    // one full four-phase command, then the frame check
    task automatic send_cmd(input string name, input draw_op_e op, input int x0, input int y0,
                            input int x1, input int y1, input cidx_t c);
        test_name = name;
        @(posedge clk_sys);
        cmd_op   <= op;
        cmd_x0   <= coord_t'(x0);
        cmd_y0   <= coord_t'(y0);
        cmd_x1   <= coord_t'(x1);
        cmd_y1   <= coord_t'(y1);
        cmd_cidx <= c;
        cmd_req  <= 1'b1;
        wait_ack(1'b1);
        @(posedge clk_sys);
        cmd_req <= 1'b0;
        wait_ack(1'b0);
        draw_shadow(op, x0, y0, x1, y1, c);
        check_frame();
    endtask

    // frame comparer, starts on a vid_frame once armed
    always @(negedge clk_sys) begin
        logic [23:0] exp_rgb;
        if (compare_en && win_left == 0 && vid_frame) begin
            win_left    = FRAME_CYCLES + 1;  // runs into the next pulse
            de_count    = 0;
            frame_count = 0;
        end
        if (win_left > 0) begin
            if (vid_frame) frame_count++;
            if (vid_de && win_left > 1) begin
                de_count++;
                exp_rgb = expected_rgb(vid_sx, vid_sy);
                assert ({vid_r, vid_g, vid_b} == exp_rgb) else begin
                    value_errors++;
                    $display("FAILED %s: pixel (%0d,%0d) expected %06h actual %06h",
                             test_name, vid_sx, vid_sy, exp_rgb, {vid_r, vid_g, vid_b});
                end
            end
            win_left--;
            if (win_left == 0) begin  // first cycle of the next frame
                assert (de_count == H_ACTIVE * V_ACTIVE) else begin
                    value_errors++;
                    $display("FAILED %s: enabled pixels expected %0d actual %0d",
                             test_name, H_ACTIVE * V_ACTIVE, de_count);
                end
                assert (frame_count == 2) else begin
                    value_errors++;
                    $display("FAILED %s: frame pulses expected 2 actual %0d",
                             test_name, frame_count);
                end
                assert (vid_frame == 1'b1) else begin
                    value_errors++;
                    $display("FAILED %s: vid_frame after %0d cycles expected 1 actual %0b",
                             test_name, FRAME_CYCLES, vid_frame);
                end
                compare_en   = 1'b0;
                compare_done = 1'b1;
            end
        end
    end

    initial begin
        int i, xa, xb, ya, yb, t;
        void'($urandom(32'h3eff_ca52));
        rst_sys  <= 1'b1;
        cmd_req  <= 1'b0;
        cmd_op   <= OP_NOP;
        cmd_x0   <= '0;
        cmd_y0   <= '0;
        cmd_x1   <= '0;
        cmd_y1   <= '0;
        cmd_cidx <= '0;
        repeat (3) @(posedge clk_sys);
        rst_sys <= 1'b0;  // three edges in reset

        send_cmd("clear", OP_CLEAR, 0, 0, 0, 0, 4'd5);
        send_cmd("rect_inside", OP_RECT, 3, 2, 9, 7, 4'd10);
        send_cmd("rect_neg_corner", OP_RECT, -3, -2, 4, 3, 4'd2);
        send_cmd("rect_far_edge", OP_RECT, 12, 9, 20, 15, 4'd12);
        send_cmd("rect_empty", OP_RECT, 8, 5, 6, 9, 4'd1);
        send_cmd("nop", OP_NOP, 1, 1, 5, 5, 4'd3);

        for (i = 0; i < 20; i++) begin
            xa = int'($urandom_range(FB_WIDTH + 7)) - 4;  // some off the edges
            xb = int'($urandom_range(FB_WIDTH + 7)) - 4;
            ya = int'($urandom_range(FB_HEIGHT + 7)) - 4;
            yb = int'($urandom_range(FB_HEIGHT + 7)) - 4;
            if (xb < xa) begin
                t  = xa;
                xa = xb;
                xb = t;
            end
            if (yb < ya) begin
                t  = ya;
                ya = yb;
                yb = t;
            end
            send_cmd($sformatf("random_%0d", i), OP_RECT, xa, ya, xb, yb,
                     cidx_t'($urandom_range(15)));
        end

        finish_run();
    end

endmodule

/* fb_demo_top.f */
gfx_pkg.sv
video_pkg.sv
pix_if.sv
display_timing.sv
render_rect.sv
bitmap_addr.sv
bram_sdp.sv
scanout.sv
fb_demo_top.sv
fb_demo_checker.sv
tb_fb_demo.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass message in the output
verilator --binary --timing --assert -Wno-fatal --top-module tb_fb_demo \
    -f fb_demo_top.f -o sim_fb_demo \
    && ./obj_dir/sim_fb_demo +verilator+error+limit+1000 | tee /dev/stderr \
    | grep "Test passed" > /dev/null \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }
